/* invaders_pkg.sv */
`default_nettype none

package invaders_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        logic       game_over;
        logic       game_win;
        logic [1:0] lives;
    } status_t;

    // Playfield in pixels
    localparam int SCREEN_WIDTH  = 640;
    localparam int SCREEN_HEIGHT = 480;

    // Alien grid
    localparam int   ALIEN_W         = 16;
    localparam int   ALIEN_H         = 16;
    localparam int   ALIEN_H_SPACING = 60;
    localparam int   ALIEN_V_SPACING = 45;
    localparam pos_t ALIEN_START     = '{x: 10'd50, y: 10'd50};
    localparam int   ALIEN_STEP      = 2;
    localparam int   ALIEN_DROP      = 20;

    // Player ship and projectiles
    localparam int     SHIP_W       = 16;
    localparam int     SHIP_H       = 30;
    localparam coord_t SHIP_Y       = 10'd440;
    localparam coord_t SHIP_START_X = 10'd320;
    localparam int     ROCKET_W     = 7;
    localparam int     ROCKET_H     = 3;
    localparam int     ROCKET_SPEED = 2;
    localparam int     LASER_W      = 7;
    localparam int     LASER_H      = 3;
    localparam int     LASER_SPEED  = 1;

    // Game rules
    localparam logic [5:0]  EXPLOSION_TICKS = 6'd35;
    localparam logic [1:0]  START_LIVES     = 2'd3;
    localparam logic [7:0]  POINTS_PER_KILL = 8'd10;
    localparam logic [7:0]  START_PERIOD    = 8'd8;
    localparam logic [15:0] LFSR_SEED       = 16'hACE1;

    // Word indices on the Wishbone bus
    localparam logic [2:0] REG_CONTROL    = 3'd0;
    localparam logic [2:0] REG_STATUS     = 3'd1;
    localparam logic [2:0] REG_SCORE      = 3'd2;
    localparam logic [2:0] REG_HIGH_SCORE = 3'd3;
    localparam logic [2:0] REG_SHIP_X     = 3'd4;
    localparam logic [2:0] REG_ALIVE      = 3'd5;

endpackage

`default_nettype wire

/* alien_fleet.sv */
`timescale 1ns/1ps
`default_nettype none

module alien_fleet #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             step,
    input  wire logic                             restart,
    input  wire logic                             kill,
    input  wire logic [4:0]                       kill_index,
    input  wire logic                             period_dec,
    output invaders_pkg::pos_t                    fleet_origin,
    output logic [ALIEN_COLS*ALIEN_ROWS-1:0]      alive,
    output logic                                  bottom_reached
);
    import invaders_pkg::*;

    logic                  dir_right;
    logic [7:0]            period;
    logic [7:0]            count;
    logic [ALIEN_COLS-1:0] col_live;
    logic [ALIEN_ROWS-1:0] row_live;
    int                    left_col;
    int                    right_col;
    int                    low_row;
    coord_t                left_edge;
    coord_t                right_edge;
    coord_t                bottom_edge;
    logic                  hit_edge;

    // Which columns and rows still hold a living alien
    always_comb begin
        col_live = '0;
        row_live = '0;
        for (int r = 0; r < ALIEN_ROWS; r++) begin
            for (int c = 0; c < ALIEN_COLS; c++) begin
                if (alive[r*ALIEN_COLS + c]) begin
                    col_live[c] = 1'b1;
                    row_live[r] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        left_col  = 0;
        right_col = 0;
        low_row   = 0;
        for (int c = ALIEN_COLS - 1; c >= 0; c--) begin
            if (col_live[c]) left_col = c;
        end
        for (int c = 0; c < ALIEN_COLS; c++) begin
            if (col_live[c]) right_col = c;
        end
        for (int r = 0; r < ALIEN_ROWS; r++) begin
            if (row_live[r]) low_row = r;
        end
    end

    assign left_edge   = fleet_origin.x + coord_t'(left_col * ALIEN_H_SPACING);
    assign right_edge  = fleet_origin.x + coord_t'(right_col * ALIEN_H_SPACING + ALIEN_W);
    assign bottom_edge = fleet_origin.y + coord_t'(low_row * ALIEN_V_SPACING + ALIEN_H);

    // Next step would carry the outermost living column off screen
    assign hit_edge = dir_right ? (right_edge + ALIEN_STEP > SCREEN_WIDTH)
                                : (left_edge < ALIEN_STEP);

    assign bottom_reached = (|alive) && (bottom_edge >= SHIP_Y - 50);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fleet_origin <= ALIEN_START;
            dir_right    <= 1'b1;
            period       <= START_PERIOD;
            count        <= '0;
            alive        <= '1;
        end else if (restart) begin
            fleet_origin <= ALIEN_START;
            dir_right    <= 1'b1;
            period       <= START_PERIOD;
            count        <= '0;
            alive        <= '1;
        end else if (step) begin
            if (kill) begin
                alive[kill_index] <= 1'b0;
            end
            if (period_dec && period > 8'd1) begin
                period <= period - 8'd1;
            end
            if (count + 8'd1 >= period) begin
                count <= '0;
                if (hit_edge) begin
                    dir_right      <= !dir_right;
                    fleet_origin.y <= fleet_origin.y + coord_t'(ALIEN_DROP);
                end else if (dir_right) begin
                    fleet_origin.x <= fleet_origin.x + coord_t'(ALIEN_STEP);
                end else begin
                    fleet_origin.x <= fleet_origin.x - coord_t'(ALIEN_STEP);
                end
            end else begin
                count <= count + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* rocket_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rocket_unit #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             step,
    input  wire logic                             restart,
    input  wire logic                             fire,
    input  wire logic                             left,
    input  wire logic                             right,
    input  wire logic                             ship_hit,
    input  wire invaders_pkg::pos_t               fleet_origin,
    input  wire logic [ALIEN_COLS*ALIEN_ROWS-1:0] alive,
    output invaders_pkg::pos_t                    ship_pos,
    output logic                                  kill,
    output logic [4:0]                            kill_index
);
    import invaders_pkg::*;

    coord_t     ship_x;
    logic [5:0] explode_timer;
    logic       rocket_active;
    pos_t       rocket;
    logic       hit;

    assign ship_pos = '{x: ship_x, y: SHIP_Y};

    // Walk downwards so the lowest index wins
    always_comb begin
        coord_t ax;
        coord_t ay;
        hit        = 1'b0;
        kill_index = '0;
        for (int i = ALIEN_COLS*ALIEN_ROWS - 1; i >= 0; i--) begin
            ax = fleet_origin.x + coord_t'((i % ALIEN_COLS) * ALIEN_H_SPACING);
            ay = fleet_origin.y + coord_t'((i / ALIEN_COLS) * ALIEN_V_SPACING);
            if (alive[i] && rocket.x < ax + ALIEN_W && rocket.x + ROCKET_W > ax
                    && rocket.y < ay + ALIEN_H && rocket.y + ROCKET_H > ay) begin
                hit        = 1'b1;
                kill_index = 5'(i);
            end
        end
    end

    assign kill = step && rocket_active && hit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ship_x        <= SHIP_START_X;
            explode_timer <= '0;
            rocket_active <= 1'b0;
            rocket        <= '0;
        end else if (restart) begin
            ship_x        <= SHIP_START_X;
            explode_timer <= '0;
            rocket_active <= 1'b0;
            rocket        <= '0;
        end else if (step) begin
            // Right takes priority when both buttons are held
            if (right) begin
                if (ship_x < SCREEN_WIDTH - SHIP_W - 1) ship_x <= ship_x + 1'b1;
            end else if (left && ship_x > 1) begin
                ship_x <= ship_x - 1'b1;
            end

            if (ship_hit) begin
                explode_timer <= EXPLOSION_TICKS;
            end else if (explode_timer != '0) begin
                explode_timer <= explode_timer - 1'b1;
            end

            if (kill) begin
                rocket_active <= 1'b0;
            end else if (rocket_active) begin
                if (rocket.y < ROCKET_SPEED) begin
                    rocket_active <= 1'b0;
                end else begin
                    rocket.y <= rocket.y - coord_t'(ROCKET_SPEED);
                end
            end else if (fire && explode_timer == '0) begin
                rocket_active <= 1'b1;
                rocket.x      <= ship_x + coord_t'((SHIP_W - ROCKET_W) / 2);
                rocket.y      <= SHIP_Y - coord_t'(ROCKET_H);
            end
        end
    end

endmodule

`default_nettype wire

/* alien_laser.sv */
`timescale 1ns/1ps
`default_nettype none

module alien_laser #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             step,
    input  wire logic                             restart,
    input  wire invaders_pkg::pos_t               fleet_origin,
    input  wire logic [ALIEN_COLS*ALIEN_ROWS-1:0] alive,
    input  wire invaders_pkg::pos_t               ship_pos,
    output logic                                  ship_hit
);
    import invaders_pkg::*;

    localparam int CW = $clog2(ALIEN_COLS + 1);
    localparam int RW = $clog2(ALIEN_ROWS + 1);

    logic [15:0]   lfsr;
    logic          laser_active;
    pos_t          laser;
    logic [CW-1:0] scan_col;
    logic [RW-1:0] scan_row;
    logic          can_shoot;
    coord_t        shoot_x;
    coord_t        shoot_y;
    logic          overlap;

    // Fibonacci LFSR, taps 16 14 13 11
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (restart) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Scanned alien lives and nothing alive below it in its column
    always_comb begin
        can_shoot = alive[int'(scan_row) * ALIEN_COLS + int'(scan_col)];
        for (int r = 0; r < ALIEN_ROWS; r++) begin
            if (r > int'(scan_row) && alive[r*ALIEN_COLS + int'(scan_col)]) begin
                can_shoot = 1'b0;
            end
        end
    end

    assign shoot_x = fleet_origin.x
                   + coord_t'(int'(scan_col) * ALIEN_H_SPACING + (ALIEN_W - LASER_W) / 2);
    assign shoot_y = fleet_origin.y + coord_t'(int'(scan_row) * ALIEN_V_SPACING + ALIEN_H);

    assign overlap = laser.x < ship_pos.x + SHIP_W && laser.x + LASER_W > ship_pos.x
                  && laser.y < ship_pos.y + SHIP_H && laser.y + LASER_H > ship_pos.y;

    assign ship_hit = step && laser_active && overlap;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            laser_active <= 1'b0;
            laser        <= '0;
            scan_col     <= '0;
            scan_row     <= '0;
        end else if (restart) begin
            laser_active <= 1'b0;
            laser        <= '0;
            scan_col     <= '0;
            scan_row     <= '0;
        end else if (step) begin
            if (ship_hit) begin
                laser_active <= 1'b0;
            end else if (laser_active) begin
                if (laser.y + LASER_H >= SCREEN_HEIGHT) begin
                    laser_active <= 1'b0;
                end else begin
                    laser.y <= laser.y + coord_t'(LASER_SPEED);
                end
            end else begin
                if (can_shoot && lfsr[0]) begin
                    laser_active <= 1'b1;
                    laser        <= '{x: shoot_x, y: shoot_y};
                end
                if (scan_col == CW'(ALIEN_COLS - 1)) begin
                    scan_col <= '0;
                    scan_row <= (scan_row == RW'(ALIEN_ROWS - 1)) ? '0 : scan_row + 1'b1;
                end else begin
                    scan_col <= scan_col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* game_status.sv */
`timescale 1ns/1ps
`default_nettype none

module game_status #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             step,
    input  wire logic                             restart,
    input  wire logic                             kill,
    input  wire logic                             ship_hit,
    input  wire logic                             bottom_reached,
    input  wire logic [ALIEN_COLS*ALIEN_ROWS-1:0] alive,
    output invaders_pkg::status_t                 status,
    output logic [7:0]                            score,
    output logic [7:0]                            high_score,
    output logic                                  period_dec
);
    import invaders_pkg::*;

    logic [1:0] kill_count;

    // Fleet speeds up on every third kill
    assign period_dec = step && kill && kill_count == 2'd2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status     <= '{game_over: 1'b0, game_win: 1'b0, lives: START_LIVES};
            score      <= '0;
            high_score <= '0;
            kill_count <= '0;
        end else begin
            if (score > high_score) high_score <= score;

            if (restart) begin
                status     <= '{game_over: 1'b0, game_win: 1'b0, lives: START_LIVES};
                score      <= '0;
                kill_count <= '0;
            end else begin
                if (step && kill) begin
                    score      <= score + POINTS_PER_KILL;
                    kill_count <= (kill_count == 2'd2) ? 2'd0 : kill_count + 2'd1;
                end
                if (step && ship_hit && status.lives != 2'd0) begin
                    status.lives <= status.lives - 2'd1;
                end
                // Flags follow one edge after their cause
                if (status.lives == 2'd0 || bottom_reached) status.game_over <= 1'b1;
                if (alive == '0) status.game_win <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* invaders_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module invaders_regs #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             frame_tick,
    input  wire logic                             wb_cyc,
    input  wire logic                             wb_stb,
    input  wire logic                             wb_we,
    input  wire logic [2:0]                       wb_adr,
    input  wire logic [31:0]                      wb_dat_w,
    output logic [31:0]                           wb_dat_r,
    output logic                                  wb_ack,
    input  wire invaders_pkg::status_t            status,
    input  wire logic [7:0]                       score,
    input  wire logic [7:0]                       high_score,
    input  wire invaders_pkg::pos_t               ship_pos,
    input  wire logic [ALIEN_COLS*ALIEN_ROWS-1:0] alive,
    output logic                                  step,
    output logic                                  restart
);
    import invaders_pkg::*;

    logic        run;
    logic        req;
    logic [31:0] read_data;

    assign req  = wb_cyc && wb_stb && !wb_ack;
    assign step = frame_tick && run && !status.game_over && !status.game_win;

    always_comb begin
        case (wb_adr)
            REG_CONTROL:    read_data = {31'b0, run};
            REG_STATUS:     read_data = 32'(status);
            REG_SCORE:      read_data = 32'(score);
            REG_HIGH_SCORE: read_data = 32'(high_score);
            REG_SHIP_X:     read_data = 32'(ship_pos.x);
            REG_ALIVE:      read_data = 32'(alive);
            default:        read_data = '0;
        endcase
    end

    // Single-cycle ack, restart bit self-clears
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run     <= 1'b0;
            wb_ack  <= 1'b0;
            restart <= 1'b0;
        end else begin
            wb_ack  <= req;
            restart <= 1'b0;
            if (req && wb_we && wb_adr == REG_CONTROL) begin
                run     <= wb_dat_w[0];
                restart <= wb_dat_w[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= read_data;
    end

endmodule

`default_nettype wire

/* invaders_top.sv */
`timescale 1ns/1ps
`default_nettype none

module invaders_top #(
    parameter int ALIEN_COLS = 6,
    parameter int ALIEN_ROWS = 3
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        frame_tick,
    input  wire logic        fire,
    input  wire logic        left,
    input  wire logic        right,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [2:0]  wb_adr,
    input  wire logic [31:0] wb_dat_w,
    output logic [31:0]      wb_dat_r,
    output logic             wb_ack
);
    import invaders_pkg::*;

    logic                             step;
    logic                             restart;
    pos_t                             fleet_origin;
    pos_t                             ship_pos;
    logic [ALIEN_COLS*ALIEN_ROWS-1:0] alive;
    logic                             bottom_reached;
    logic                             kill;
    logic [4:0]                       kill_index;
    logic                             ship_hit;
    logic                             fleet_period_dec;
    status_t                          status;
    logic [7:0]                       score;
    logic [7:0]                       high_score;

    invaders_regs #(.ALIEN_COLS(ALIEN_COLS), .ALIEN_ROWS(ALIEN_ROWS)) u_regs (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .status     (status),
        .score      (score),
        .high_score (high_score),
        .ship_pos   (ship_pos),
        .alive      (alive),
        .step       (step),
        .restart    (restart)
    );

    alien_fleet #(.ALIEN_COLS(ALIEN_COLS), .ALIEN_ROWS(ALIEN_ROWS)) u_fleet (
        .clk            (clk),
        .reset          (reset),
        .step           (step),
        .restart        (restart),
        .kill           (kill),
        .kill_index     (kill_index),
        .period_dec     (fleet_period_dec),
        .fleet_origin   (fleet_origin),
        .alive          (alive),
        .bottom_reached (bottom_reached)
    );

    rocket_unit #(.ALIEN_COLS(ALIEN_COLS), .ALIEN_ROWS(ALIEN_ROWS)) u_rocket (
        .clk          (clk),
        .reset        (reset),
        .step         (step),
        .restart      (restart),
        .fire         (fire),
        .left         (left),
        .right        (right),
        .ship_hit     (ship_hit),
        .fleet_origin (fleet_origin),
        .alive        (alive),
        .ship_pos     (ship_pos),
        .kill         (kill),
        .kill_index   (kill_index)
    );

    alien_laser #(.ALIEN_COLS(ALIEN_COLS), .ALIEN_ROWS(ALIEN_ROWS)) u_laser (
        .clk          (clk),
        .reset        (reset),
        .step         (step),
        .restart      (restart),
        .fleet_origin (fleet_origin),
        .alive        (alive),
        .ship_pos     (ship_pos),
        .ship_hit     (ship_hit)
    );

    game_status #(.ALIEN_COLS(ALIEN_COLS), .ALIEN_ROWS(ALIEN_ROWS)) u_status (
        .clk            (clk),
        .reset          (reset),
        .step           (step),
        .restart        (restart),
        .kill           (kill),
        .ship_hit       (ship_hit),
        .bottom_reached (bottom_reached),
        .alive          (alive),
        .status         (status),
        .score          (score),
        .high_score     (high_score),
        .period_dec     (fleet_period_dec)
    );

endmodule

`default_nettype wire

/* tb_invaders.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_invaders;
    import invaders_pkg::*;

    localparam int          ALIEN_COUNT  = 18;
    localparam logic [31:0] FULL_MASK    = (32'd1 << ALIEN_COUNT) - 32'd1;
    localparam int          ACK_TIMEOUT  = 20;
    localparam int          KILL_TIMEOUT = 4000;
    localparam int          END_TIMEOUT  = 20000;

    logic        clk;
    logic        reset;
    logic        frame_tick;
    logic        fire;
    logic        left;
    logic        right;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    int          errors;
    integer      seed;

    invaders_top #(.ALIEN_COLS(6), .ALIEN_ROWS(3)) UUT (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .fire       (fire),
        .left       (left),
        .right      (right),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // One classic bus cycle as master with ack sampled on the falling edge
    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (wb_ack) else begin
            errors++;
            $display("Bus access to word %0d was never acknowledged", adr);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic expect_reg(input string name, input logic [2:0] adr,
                              input logic [31:0] expected);
        logic [31:0] data;
        wb_read(adr, data);
        check_value(name, data, expected);
    endtask

    task automatic tick();
        @(posedge clk);
        frame_tick <= 1'b1;
        @(posedge clk);
        frame_tick <= 1'b0;
    endtask

    function automatic int count_cleared(input logic [31:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < ALIEN_COUNT; i++) begin
            if (!mask[i]) n++;
        end
        return n;
    endfunction

    task automatic reset_values();
        expect_reg("control", REG_CONTROL, 32'h0);
        expect_reg("status", REG_STATUS, 32'h3);
        expect_reg("score", REG_SCORE, 32'h0);
        expect_reg("high_score", REG_HIGH_SCORE, 32'h0);
        expect_reg("ship_x", REG_SHIP_X, 32'd320);
        expect_reg("alive", REG_ALIVE, FULL_MASK);
    endtask

    task automatic ship_movement();
        int n;
        int m;
        n = $unsigned($random(seed)) % 41;
        m = $unsigned($random(seed)) % 41;
        wb_write(REG_CONTROL, 32'h3);
        @(posedge clk);
        right <= 1'b1;
        repeat (n) tick();
        @(posedge clk);
        right <= 1'b0;
        left  <= 1'b1;
        repeat (m) tick();
        @(posedge clk);
        left <= 1'b0;
        expect_reg("ship_x", REG_SHIP_X, 32'(320 + n - m));
        // Fresh game so the long walk left starts from the middle
        wb_write(REG_CONTROL, 32'h3);
        @(posedge clk);
        left <= 1'b1;
        repeat (400) tick();
        @(posedge clk);
        left <= 1'b0;
        expect_reg("ship_x", REG_SHIP_X, 32'd1);
    endtask

    task automatic step_gating();
        logic [31:0] ship_x;
        logic [31:0] status;
        logic [31:0] score;
        logic [31:0] alive;
        // Restart with run clear puts the ship back in the middle
        wb_write(REG_CONTROL, 32'h2);
        ship_x = 32'd320;
        @(posedge clk);
        left <= 1'b1;
        repeat (10) tick();
        expect_reg("ship_x", REG_SHIP_X, ship_x);
        wb_write(REG_CONTROL, 32'h1);
        wb_read(REG_STATUS, status);
        wb_read(REG_SCORE, score);
        wb_read(REG_ALIVE, alive);
        repeat (50) @(posedge clk);
        expect_reg("ship_x", REG_SHIP_X, ship_x);
        expect_reg("status", REG_STATUS, status);
        expect_reg("score", REG_SCORE, score);
        expect_reg("alive", REG_ALIVE, alive);
        @(posedge clk);
        left <= 1'b0;
    endtask

    task automatic rocket_kills();
        logic [31:0] alive;
        logic [31:0] score;
        logic [31:0] high;
        logic [31:0] status;
        int          cleared;
        int          seen;
        int          waited;
        seen   = 0;
        waited = 0;
        status = 32'h0;
        wb_write(REG_CONTROL, 32'h3);
        @(posedge clk);
        fire <= 1'b1;
        while (seen < 3 && !status[3] && waited < KILL_TIMEOUT) begin
            tick();
            waited++;
            wb_read(REG_ALIVE, alive);
            cleared = count_cleared(alive);
            if (cleared != seen) begin
                seen = cleared;
                wb_read(REG_SCORE, score);
                wb_read(REG_HIGH_SCORE, high);
                check_value("score", score, 32'(10 * cleared));
                assert (high >= score) else begin
                    errors++;
                    $display("FAILED high_score: %h below score %h", high, score);
                end
            end
            wb_read(REG_STATUS, status);
        end
        @(posedge clk);
        fire <= 1'b0;
        assert (seen > 0) else begin
            errors++;
            $display("No alien was hit by a rocket before the timeout");
        end
    endtask

    task automatic game_end_restart();
        logic [31:0] status;
        logic [31:0] ship_x;
        logic [31:0] high;
        int          waited;
        waited = 0;
        status = 32'h0;
        while (!status[3] && waited < END_TIMEOUT) begin
            tick();
            waited++;
            wb_read(REG_STATUS, status);
        end
        assert (status[3]) else begin
            errors++;
            $display("Game never reached game over before the timeout");
        end
        wb_read(REG_SHIP_X, ship_x);
        @(posedge clk);
        left <= 1'b1;
        repeat (5) tick();
        @(posedge clk);
        left <= 1'b0;
        expect_reg("ship_x", REG_SHIP_X, ship_x);
        wb_read(REG_HIGH_SCORE, high);
        wb_write(REG_CONTROL, 32'h3);
        expect_reg("score", REG_SCORE, 32'h0);
        expect_reg("status", REG_STATUS, 32'h3);
        expect_reg("alive", REG_ALIVE, FULL_MASK);
        expect_reg("high_score", REG_HIGH_SCORE, high);
    endtask

    initial begin
        errors     = 0;
        seed       = 32'hd7b3_a3de;
        reset      <= 1'b1;
        frame_tick <= 1'b0;
        fire       <= 1'b0;
        left       <= 1'b0;
        right      <= 1'b0;
        wb_cyc     <= 1'b0;
        wb_stb     <= 1'b0;
        wb_we      <= 1'b0;
        wb_adr     <= 3'd0;
        wb_dat_w   <= 32'h0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        reset_values();
        ship_movement();
        step_gating();
        rocket_kills();
        game_end_restart();

        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
invaders_pkg.sv
alien_fleet.sv
rocket_unit.sv
alien_laser.sv
game_status.sv
invaders_regs.sv
invaders_top.sv
tb_invaders.sv

/* Bender.yml */
package:
  name: invaders

sources:
  - invaders_pkg.sv
  - alien_fleet.sv
  - rocket_unit.sv
  - alien_laser.sv
  - game_status.sv
  - invaders_regs.sv
  - invaders_top.sv
  - target: simulation
    files:
      - tb_invaders.sv
